// File: bench/rvCoreTb.sv
// Top-level testbench for rvCore that runs a random RV32I stream against a reference model
`default_nettype none

module rvCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numInstr = 3000;
    // Two cycles per instruction at worst plus reset and drain
    localparam int timeoutCycles = 2 * numInstr + 100;
    localparam logic [31:0] seed = 32'h0d54_e15a;

    logic        clock = 1'b0;
    logic        rst;
    logic        instrValid;
    logic [31:0] instruction;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic        illegal;

    // Reference state
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [64];
    logic [31:0] modelPc;

    // Loads only target words already stored
    bit          storedWord [64];
    bit          anyStored;
    logic [5:0]  lastStored;

    // Expected outcome delay line with slot 1 due this cycle
    logic        pipeWb [2];
    logic        pipeIll [2];
    logic [4:0]  pipeRd [2];
    logic [31:0] pipeData [2];

    logic [31:0] rngState;
    logic        genValid;
    logic [31:0] genInstr;
    int          cycleCount = 0;
    int          issued;
    bit          runPassed = 1'b0;
    bit          failPrinted = 1'b0;

    rvCore rvCore_inst (
        .clock(clock), .rst(rst), .instrValid(instrValid), .instruction(instruction),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData), .illegal(illegal)
    );

    // Strobe timing rules checked inside the DUT
    bind rvCore rvCore_assert rvCore_assert_inst (
        .clock(clock), .rst(rst), .instrValid(instrValid),
        .wbValid(wbValid), .wbRd(wbRd), .illegal(illegal)
    );

    always
    begin
        #2 clock = ~clock;
    end

    // Run limit in clock cycles
    always @(posedge clock)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutCycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            failPrinted = 1'b1;
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped on timeout");
        end
    end

    // Covers a stop raised by a failing assertion
    final
    begin
        if (!runPassed && !failPrinted)
            $display("TEST RESULT: FAIL");
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Half the picks fall in x0..x7 so dependent pairs show up often
    function automatic logic [4:0] pickReg(input logic [5:0] bits);
        return bits[5] ? {2'b00, bits[2:0]} : bits[4:0];
    endfunction

    // RV32I integer semantics by func3 with alt taken from func7 bit 5
    function automatic logic [31:0] aluModel(input logic [2:0] func3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (func3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic checkValue(input string signalName, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED at %0d ns: %s is %h, expected %h",
                     $time, signalName, actual, expected);
            failPrinted = 1'b1;
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Applies one instruction to the model and queues its outcome
    task automatic modelIssue(input logic [31:0] instr);
        logic [4:0]  rd;
        logic [2:0]  func3;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immU;
        logic [31:0] addr;
        logic [31:0] result;
        logic        writes;
        rd = instr[11:7];
        func3 = instr[14:12];
        opA = modelRegs[instr[19:15]];
        opB = modelRegs[instr[24:20]];
        immI = {{20{instr[31]}}, instr[31:20]};
        immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immU = {instr[31:12], 12'b0};
        result = '0;
        writes = 1'b1;
        pipeIll[0] = 1'b0;
        case (instr[6:0])
            rvPkg::opLui:   result = immU;
            // PC of this instruction before the step
            rvPkg::opAuipc: result = modelPc + immU;
            rvPkg::opImm:   result = aluModel(func3, func3 == 3'b101 && instr[30], opA, immI);
            rvPkg::opReg:   result = aluModel(func3, instr[30], opA, opB);
            rvPkg::opLoad:
            begin
                addr = opA + immI;
                result = modelMem[addr[7:2]];
                writes = (func3 == 3'b010);
                pipeIll[0] = !writes;
            end
            rvPkg::opStore:
            begin
                addr = opA + immS;
                writes = 1'b0;
                if (func3 == 3'b010)
                    modelMem[addr[7:2]] = opB;
                else
                    pipeIll[0] = 1'b1;
            end
            default:
            begin
                writes = 1'b0;
                pipeIll[0] = 1'b1;
            end
        endcase
        // x0 swallows the result with no pulse
        pipeWb[0] = writes && rd != 5'd0;
        pipeRd[0] = rd;
        pipeData[0] = result;
        if (pipeWb[0])
            modelRegs[rd] = result;
        modelPc = modelPc + 32'd4;
    endtask

    task automatic makeInstruction(output logic valid, output logic [31:0] instr);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  func3;
        logic [6:0]  func7;
        logic [11:0] imm;
        logic [5:0]  word;
        logic [6:0]  opc;
        rngState = xorshift(rngState);
        r1 = rngState;
        rngState = xorshift(rngState);
        r2 = rngState;
        kind = r1[3:0];
        func3 = r1[6:4];
        rd = pickReg(r2[5:0]);
        rs1 = pickReg(r2[11:6]);
        rs2 = pickReg(r2[17:12]);
        word = r1[13:8];
        valid = 1'b1;
        // Store first if nothing is there to load yet
        if ((kind == 4'd13 || kind == 4'd14) && !anyStored)
            kind = 4'd11;
        case (kind)
            4'd0:
            begin
                // Idle slot with junk on the bus
                valid = 1'b0;
                instr = r2;
            end
            4'd1: instr = {r1[31:12], rd, rvPkg::opLui};
            4'd2: instr = {r1[31:12], rd, rvPkg::opAuipc};
            4'd3, 4'd4, 4'd5, 4'd6:
            begin
                imm = r1[31:20];
                if (func3 == 3'b001)
                    imm = {7'b0, r1[24:20]};
                else if (func3 == 3'b101)
                    imm = {1'b0, r1[7], 5'b0, r1[24:20]};
                instr = {imm, rs1, func3, rd, rvPkg::opImm};
            end
            4'd7, 4'd8, 4'd9, 4'd10:
            begin
                func7 = ((func3 == 3'b000 || func3 == 3'b101) && r1[7]) ? 7'b0100000 : 7'b0;
                instr = {func7, rs2, rs1, func3, rd, rvPkg::opReg};
            end
            4'd11, 4'd12:
            begin
                // SW to x0 plus a word offset
                imm = {4'b0, word, 2'b00};
                instr = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rvPkg::opStore};
                storedWord[word] = 1'b1;
                anyStored = 1'b1;
                lastStored = word;
            end
            4'd13, 4'd14:
            begin
                if (!storedWord[word])
                    word = lastStored;
                imm = {4'b0, word, 2'b00};
                instr = {imm, 5'd0, 3'b010, rd, rvPkg::opLoad};
            end
            default:
            begin
                // Opcode with bit 6 set or a non-word load or store
                if (r1[7])
                    instr = {r2[31:7], 1'b1, r2[5:0]};
                else
                begin
                    opc = r1[8] ? rvPkg::opLoad : rvPkg::opStore;
                    instr = {r2[31:15], (func3 == 3'b010) ? 3'b011 : func3, r2[11:7], opc};
                end
            end
        endcase
    endtask

    // Wait one clock and check what is due before driving the next slot
    task automatic stepCycle(input logic valid, input logic [31:0] instr);
        @(posedge clock);
        #1;
        checkValue("wbValid", {31'b0, wbValid}, {31'b0, pipeWb[1]});
        checkValue("illegal", {31'b0, illegal}, {31'b0, pipeIll[1]});
        if (pipeWb[1])
        begin
            checkValue("wbRd", {27'b0, wbRd}, {27'b0, pipeRd[1]});
            checkValue("wbData", wbData, pipeData[1]);
        end
        pipeWb[1] = pipeWb[0];
        pipeIll[1] = pipeIll[0];
        pipeRd[1] = pipeRd[0];
        pipeData[1] = pipeData[0];
        pipeWb[0] = 1'b0;
        pipeIll[0] = 1'b0;
        instrValid = valid;
        instruction = instr;
        if (valid)
            modelIssue(instr);
    endtask

    initial
    begin
        rngState = seed;
        modelPc = '0;
        anyStored = 1'b0;
        lastStored = '0;
        issued = 0;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;
        for (int i = 0; i < 64; i++)
            storedWord[i] = 1'b0;
        for (int i = 0; i < 2; i++)
        begin
            pipeWb[i] = 1'b0;
            pipeIll[i] = 1'b0;
        end
        rst = 1'b1;
        instrValid = 1'b0;
        instruction = '0;
        repeat (3) @(posedge clock);
        #1;
        rst = 1'b0;
        // Outputs stay quiet with nothing issued
        repeat (8) stepCycle(1'b0, 32'h0);
        while (issued < numInstr)
        begin
            makeInstruction(genValid, genInstr);
            stepCycle(genValid, genInstr);
            if (genValid)
                issued++;
        end
        // Drain the two in flight
        repeat (3) stepCycle(1'b0, 32'h0);
        runPassed = 1'b1;
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/rvCore_assert.sv
// Timing checks on the rvCore result strobes, attached to the core by a bind in the testbench
`default_nettype none

module rvCore_assert (
    input wire                             clock,
    input wire                             rst,
    input wire                             instrValid,
    input wire                             wbValid,
    input wire [rvPkg::regAddrBits-1:0]    wbRd,
    input wire                             illegal
);
    timeunit 1ns;
    timeprecision 100ps;

    // A result strobe always traces back to an accepted instruction
    resultFollowsIssue: assert property (@(posedge clock) disable iff (rst)
        (wbValid || illegal) |-> $past(instrValid, 2))
        else $error("result strobe without an instruction two cycles earlier");

    // x0 is never written back
    noWritebackToZero: assert property (@(posedge clock) disable iff (rst)
        wbValid |-> (wbRd != '0))
        else $error("wbValid raised with wbRd equal to zero");

    // One instruction gives a writeback or an illegal flag, never both
    wbOrIllegal: assert property (@(posedge clock) disable iff (rst)
        !(wbValid && illegal))
        else $error("wbValid and illegal high in the same cycle");

endmodule

`default_nettype wire

// File: hdl/dataMem.sv
// Word-addressed data memory, combinational read and write at the rising edge
`default_nettype none

module dataMem (
    input  wire                             clock,
    input  wire  [rvPkg::memAddrBits-1:0]   memAddr,
    input  wire                             memWrEn,
    input  wire  [rvPkg::xlen-1:0]          memWrData,
    output logic [rvPkg::xlen-1:0]          memRdData
);

    // Storage array, undefined until written
    logic [rvPkg::xlen-1:0] mem [rvPkg::memWords];

    // Whole-word write only
    always_ff @(posedge clock)
    begin
        if (memWrEn)
            mem[memAddr] <= memWrData;
    end

    // Load data is ready in the same cycle
    assign memRdData = mem[memAddr];

endmodule

`default_nettype wire

// File: hdl/decode.sv
// Registered decode stage, splits an accepted instruction into fields, immediate and controls
`default_nettype none

module decode (
    input  wire                              clock,
    input  wire                              rst,
    input  wire                              instrValid,
    input  wire  [31:0]                      instruction,
    output logic                             exValid,
    output rvPkg::aluOpT                     exAluOp,
    output logic                             exUsePc,
    output logic                             exUseImm,
    output logic [rvPkg::xlen-1:0]           exImm,
    output logic [rvPkg::xlen-1:0]           exPc,
    output logic [rvPkg::regAddrBits-1:0]    exRd,
    output logic [rvPkg::regAddrBits-1:0]    exRs1,
    output logic [rvPkg::regAddrBits-1:0]    exRs2,
    output logic                             exRegWrite,
    output logic                             exMemRead,
    output logic                             exMemWrite,
    output logic                             exIllegal
);

    // Raw instruction fields
    rvPkg::opcodeT                opcode;
    logic [rvPkg::regAddrBits-1:0] rd;
    logic [rvPkg::regAddrBits-1:0] rs1;
    logic [rvPkg::regAddrBits-1:0] rs2;
    logic [2:0]                    func3;
    logic [6:0]                    func7;

    // Immediate formats
    logic [rvPkg::xlen-1:0] immI;
    logic [rvPkg::xlen-1:0] immS;
    logic [rvPkg::xlen-1:0] immU;
    logic [rvPkg::xlen-1:0] immShamt;

    // Decoded controls before the output register
    rvPkg::aluOpT           aluOp;
    logic                   usePc;
    logic                   useImm;
    logic [rvPkg::xlen-1:0] imm;
    logic                   regWrite;
    logic                   memRead;
    logic                   memWrite;
    logic                   illegalOp;

    // Program counter of the next accepted instruction
    logic [rvPkg::xlen-1:0] pc;

    assign opcode = rvPkg::opcodeT'(instruction[6:0]);
    assign rd     = instruction[11:7];
    assign func3  = instruction[14:12];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign func7  = instruction[31:25];

    // Sign extended I and S, U already shifted by twelve
    assign immI     = {{20{instruction[31]}}, instruction[31:20]};
    assign immS     = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immU     = {instruction[31:12], 12'b0};
    // Shift amount sits where rs2 would be
    assign immShamt = {{(rvPkg::xlen-5){1'b0}}, instruction[24:20]};

    always_comb
    begin
        aluOp     = rvPkg::aluAdd;
        usePc     = 1'b0;
        useImm    = 1'b0;
        imm       = immI;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        illegalOp = 1'b0;
        case (opcode)
            rvPkg::opLui:
            begin
                aluOp    = rvPkg::aluPassB;
                useImm   = 1'b1;
                imm      = immU;
                regWrite = 1'b1;
            end
            rvPkg::opAuipc:
            begin
                usePc    = 1'b1;
                useImm   = 1'b1;
                imm      = immU;
                regWrite = 1'b1;
            end
            rvPkg::opLoad:
            begin
                // Word loads only
                if (func3 == 3'b010)
                begin
                    useImm   = 1'b1;
                    regWrite = 1'b1;
                    memRead  = 1'b1;
                end
                else
                    illegalOp = 1'b1;
            end
            rvPkg::opStore:
            begin
                if (func3 == 3'b010)
                begin
                    useImm   = 1'b1;
                    imm      = immS;
                    memWrite = 1'b1;
                end
                else
                    illegalOp = 1'b1;
            end
            rvPkg::opImm, rvPkg::opReg:
            begin
                useImm   = (opcode == rvPkg::opImm);
                regWrite = 1'b1;
                // Shifts by immediate take shamt instead of the I immediate
                if (func3 == 3'b001 || func3 == 3'b101)
                    imm = immShamt;
                case (func3)
                    // SUB exists only in the register group
                    3'b000:  aluOp = (opcode == rvPkg::opReg && func7[5]) ?
                                     rvPkg::aluSub : rvPkg::aluAdd;
                    3'b001:  aluOp = rvPkg::aluSll;
                    3'b010:  aluOp = rvPkg::aluSlt;
                    3'b011:  aluOp = rvPkg::aluSltu;
                    3'b100:  aluOp = rvPkg::aluXor;
                    3'b101:  aluOp = func7[5] ? rvPkg::aluSra : rvPkg::aluSrl;
                    3'b110:  aluOp = rvPkg::aluOr;
                    default: aluOp = rvPkg::aluAnd;
                endcase
            end
            default:
                illegalOp = 1'b1;
        endcase
        // Results aimed at x0 are dropped here
        if (rd == '0)
            regWrite = 1'b0;
    end

    // Control state, cleared on reset
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exIllegal  <= 1'b0;
            pc         <= '0;
        end
        else
        begin
            exValid    <= instrValid;
            exRegWrite <= instrValid & regWrite;
            exMemRead  <= instrValid & memRead;
            exMemWrite <= instrValid & memWrite;
            exIllegal  <= instrValid & illegalOp;
            // PC only moves on accepted instructions
            if (instrValid)
                pc <= pc + 32'd4;
        end
    end

    // Payload, meaningful only alongside exValid
    always_ff @(posedge clock)
    begin
        exAluOp  <= aluOp;
        exUsePc  <= usePc;
        exUseImm <= useImm;
        exImm    <= imm;
        exPc     <= pc;
        exRd     <= rd;
        exRs1    <= rs1;
        exRs2    <= rs2;
    end

endmodule

`default_nettype wire

// File: hdl/execute.sv
// Execute and writeback stage, operand select, ALU, memory access and registered writeback
`default_nettype none

module execute (
    input  wire                             clock,
    input  wire                             rst,
    input  wire                             exValid,
    input  wire  rvPkg::aluOpT              exAluOp,
    input  wire                             exUsePc,
    input  wire                             exUseImm,
    input  wire  [rvPkg::xlen-1:0]          exImm,
    input  wire  [rvPkg::xlen-1:0]          exPc,
    input  wire  [rvPkg::regAddrBits-1:0]   exRd,
    input  wire  [rvPkg::regAddrBits-1:0]   exRs1,
    input  wire  [rvPkg::regAddrBits-1:0]   exRs2,
    input  wire                             exRegWrite,
    input  wire                             exMemRead,
    input  wire                             exMemWrite,
    input  wire                             exIllegal,
    input  wire  [rvPkg::xlen-1:0]          rdData1,
    input  wire  [rvPkg::xlen-1:0]          rdData2,
    input  wire  [rvPkg::xlen-1:0]          memRdData,
    output logic [rvPkg::regAddrBits-1:0]   rdAddr1,
    output logic [rvPkg::regAddrBits-1:0]   rdAddr2,
    output logic                            wrEn,
    output logic [rvPkg::regAddrBits-1:0]   wrAddr,
    output logic [rvPkg::xlen-1:0]          wrData,
    output logic [rvPkg::memAddrBits-1:0]   memAddr,
    output logic                            memWrEn,
    output logic [rvPkg::xlen-1:0]          memWrData,
    output logic                            wbValid,
    output logic [rvPkg::regAddrBits-1:0]   wbRd,
    output logic [rvPkg::xlen-1:0]          wbData,
    output logic                            illegal
);

    // ALU inputs and result
    logic [rvPkg::xlen-1:0] operandA;
    logic [rvPkg::xlen-1:0] operandB;
    logic [rvPkg::xlen-1:0] aluResult;
    logic [4:0]             shamt;

    // Register reads come straight from the decoded indices
    assign rdAddr1 = exRs1;
    assign rdAddr2 = exRs2;

    // PC feeds operand A for AUIPC
    assign operandA = exUsePc ? exPc : rdData1;
    assign operandB = exUseImm ? exImm : rdData2;
    assign shamt    = operandB[4:0];

    always_comb
    begin
        case (exAluOp)
            rvPkg::aluAdd:   aluResult = operandA + operandB;
            rvPkg::aluSub:   aluResult = operandA - operandB;
            rvPkg::aluSll:   aluResult = operandA << shamt;
            rvPkg::aluSlt:
                aluResult = {{(rvPkg::xlen-1){1'b0}},
                             ($signed(operandA) < $signed(operandB))};
            rvPkg::aluSltu:
                aluResult = {{(rvPkg::xlen-1){1'b0}}, (operandA < operandB)};
            rvPkg::aluXor:   aluResult = operandA ^ operandB;
            rvPkg::aluSrl:   aluResult = operandA >> shamt;
            // Arithmetic shift keeps the sign bit
            rvPkg::aluSra:   aluResult = $unsigned($signed(operandA) >>> shamt);
            rvPkg::aluOr:    aluResult = operandA | operandB;
            rvPkg::aluAnd:   aluResult = operandA & operandB;
            default:         aluResult = operandB;
        endcase
    end

    // Byte address bits 7 to 2 select the word
    assign memAddr   = aluResult[rvPkg::memAddrBits+1:2];
    assign memWrData = rdData2;
    assign memWrEn   = exValid & exMemWrite;

    // Load data or ALU result goes back to the register file
    assign wrEn   = exValid & exRegWrite;
    assign wrAddr = exRd;
    assign wrData = exMemRead ? memRdData : aluResult;

    // Writeback strobes, same edge as the register and memory writes
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            wbValid <= 1'b0;
            illegal <= 1'b0;
        end
        else
        begin
            wbValid <= wrEn;
            illegal <= exValid & exIllegal;
        end
    end

    // Writeback payload
    always_ff @(posedge clock)
    begin
        wbRd   <= wrAddr;
        wbData <= wrData;
    end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
// Integer register file, two combinational reads and one write per edge, x0 reads as zero
`default_nettype none

module regFile (
    input  wire                             clock,
    input  wire                             rst,
    input  wire  [rvPkg::regAddrBits-1:0]   rdAddr1,
    input  wire  [rvPkg::regAddrBits-1:0]   rdAddr2,
    input  wire                             wrEn,
    input  wire  [rvPkg::regAddrBits-1:0]   wrAddr,
    input  wire  [rvPkg::xlen-1:0]          wrData,
    output logic [rvPkg::xlen-1:0]          rdData1,
    output logic [rvPkg::xlen-1:0]          rdData2
);

    // One entry per architectural register
    logic [rvPkg::xlen-1:0] regs [2**rvPkg::regAddrBits];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < 2**rvPkg::regAddrBits; i++)
                regs[i] <= '0;
        end
        // Writes to x0 are discarded
        else if (wrEn && wrAddr != '0)
            regs[wrAddr] <= wrData;
    end

    // Reads see the value committed at the previous edge
    assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

`default_nettype wire

// File: hdl/rvCore.sv
// Top level of the RV32I core, decode feeding execute with register file and data memory
`default_nettype none

module rvCore (
    input  wire                             clock,
    input  wire                             rst,
    input  wire                             instrValid,
    input  wire  [31:0]                     instruction,
    output logic                            wbValid,
    output logic [rvPkg::regAddrBits-1:0]   wbRd,
    output logic [rvPkg::xlen-1:0]          wbData,
    output logic                            illegal
);

    // Decode to execute
    logic                           exValid;
    rvPkg::aluOpT                   exAluOp;
    logic                           exUsePc;
    logic                           exUseImm;
    logic [rvPkg::xlen-1:0]         exImm;
    logic [rvPkg::xlen-1:0]         exPc;
    logic [rvPkg::regAddrBits-1:0]  exRd;
    logic [rvPkg::regAddrBits-1:0]  exRs1;
    logic [rvPkg::regAddrBits-1:0]  exRs2;
    logic                           exRegWrite;
    logic                           exMemRead;
    logic                           exMemWrite;
    logic                           exIllegal;

    // Register file ports
    logic [rvPkg::regAddrBits-1:0]  rdAddr1;
    logic [rvPkg::regAddrBits-1:0]  rdAddr2;
    logic [rvPkg::xlen-1:0]         rdData1;
    logic [rvPkg::xlen-1:0]         rdData2;
    logic                           wrEn;
    logic [rvPkg::regAddrBits-1:0]  wrAddr;
    logic [rvPkg::xlen-1:0]         wrData;

    // Data memory ports
    logic [rvPkg::memAddrBits-1:0]  memAddr;
    logic                           memWrEn;
    logic [rvPkg::xlen-1:0]         memWrData;
    logic [rvPkg::xlen-1:0]         memRdData;

    decode decode_inst (
        .clock(clock), .rst(rst), .instrValid(instrValid), .instruction(instruction),
        .exValid(exValid), .exAluOp(exAluOp), .exUsePc(exUsePc), .exUseImm(exUseImm),
        .exImm(exImm), .exPc(exPc), .exRd(exRd), .exRs1(exRs1), .exRs2(exRs2),
        .exRegWrite(exRegWrite), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
        .exIllegal(exIllegal)
    );

    regFile regFile_inst (
        .clock(clock), .rst(rst), .rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdData1(rdData1), .rdData2(rdData2)
    );

    dataMem dataMem_inst (
        .clock(clock), .memAddr(memAddr), .memWrEn(memWrEn),
        .memWrData(memWrData), .memRdData(memRdData)
    );

    execute execute_inst (
        .clock(clock), .rst(rst), .exValid(exValid), .exAluOp(exAluOp),
        .exUsePc(exUsePc), .exUseImm(exUseImm), .exImm(exImm), .exPc(exPc),
        .exRd(exRd), .exRs1(exRs1), .exRs2(exRs2), .exRegWrite(exRegWrite),
        .exMemRead(exMemRead), .exMemWrite(exMemWrite), .exIllegal(exIllegal),
        .rdData1(rdData1), .rdData2(rdData2), .memRdData(memRdData),
        .rdAddr1(rdAddr1), .rdAddr2(rdAddr2), .wrEn(wrEn), .wrAddr(wrAddr),
        .wrData(wrData), .memAddr(memAddr), .memWrEn(memWrEn), .memWrData(memWrData),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData), .illegal(illegal)
    );

endmodule

`default_nettype wire

// File: hdl/rvPkg.sv
// Widths and encodings shared by the RV32I core RTL, referenced by scoped name from each module
`default_nettype none

package rvPkg;

    // Data path width and register index width
    localparam int xlen = 32;
    localparam int regAddrBits = 5;

    // Data memory is word addressed
    localparam int memWords = 64;
    localparam int memAddrBits = 6;

    // Major opcodes of the supported subset, RV32I encodings
    typedef enum logic [6:0] {
        // Load upper immediate
        opLui   = 7'b0110111,
        // Add upper immediate to PC
        opAuipc = 7'b0010111,
        // LW only
        opLoad  = 7'b0000011,
        // SW only
        opStore = 7'b0100011,
        // Register-immediate ALU group
        opImm   = 7'b0010011,
        // Register-register ALU group
        opReg   = 7'b0110011
    } opcodeT;

    // ALU operations chosen by decode and carried out in execute
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        // Operand B straight through, used by LUI
        aluPassB = 4'd10
    } aluOpT;

endpackage

`default_nettype wire

// File: project.f
hdl/rvPkg.sv
hdl/decode.sv
hdl/regFile.sv
hdl/dataMem.sv
hdl/execute.sv
hdl/rvCore.sv
bench/rvCore_assert.sv
bench/rvCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the rvCore testbench with Verilator, pass only if the log shows the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rvCoreTb -f project.f -o rvCoreSim

./obj_dir/rvCoreSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1
